// ==== source/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// core-wide constants
////////////////////////////////////////////////////////////////////////////

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural register count, x0 included
`define RV_NREGS 32

// addi x0, x0, 0
// loaded into the decode slot when a younger instruction is killed
`define RV_NOP 32'h0000_0013

`endif

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

  // data, address and instruction words
  typedef logic [31:0] word_t;
  // register index
  typedef logic [4:0] reg_idx_t;
  // funct3 field, branch condition or alu variant
  typedef logic [2:0] funct3_t;
  // alu operation code from decode
  typedef logic [3:0] alu_op_t;
  // major opcode field
  typedef logic [6:0] opcode_t;

  // alu operation codes
  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_AND = 4'd2;
  localparam alu_op_t ALU_OR  = 4'd3;
  localparam alu_op_t ALU_XOR = 4'd4;
  localparam alu_op_t ALU_SLT = 4'd5;
  localparam alu_op_t ALU_SLL = 4'd6;
  localparam alu_op_t ALU_SRL = 4'd7;

  // supported major opcodes
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;

endpackage

// ==== source/rv_fetch.sv ====
`include "rv_core_params.svh"

module rv_fetch import rv_core_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  redirect,
  input  word_t redirect_pc,
  output word_t addr
);

  // program counter
  word_t pc;
  word_t pc_next;

  // taken branch or jump from execute wins
  // otherwise step to the next word
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  // single pc register, one cycle update
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // fetch address straight from the register
  assign addr = pc;

endmodule

// ==== source/rv_decode_ctrl.sv ====
module rv_decode_ctrl import rv_core_pkg::*; (
  input  word_t    instr,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm,
  output funct3_t  funct3,
  output alu_op_t  alu_op,
  output logic     alu_src_imm,
  output logic     reg_wr,
  output logic     mem_rd,
  output logic     mem_wr,
  output logic     is_branch,
  output logic     is_jal,
  output logic     is_jalr,
  output logic     is_lui
);

  opcode_t    opcode;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  alu_op_t    arith_op;

  ////////////////////////////////////////////////////////////////////////////
  // field split
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // sign extended immediates, one per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  // upper immediate, low 12 bits zero
  assign imm_u = {instr[31:12], 12'b0};

  // arithmetic variant by funct3
  // funct7 bit 5 picks sub only for register-register
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      3'b111:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // control strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // unknown opcode falls out as a nop
    imm         = '0;
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    reg_wr      = 1'b0;
    mem_rd      = 1'b0;
    mem_wr      = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_lui      = 1'b0;
    case (opcode)
      OP_REG: begin
        alu_op = arith_op;
        reg_wr = 1'b1;
      end
      OP_IMM: begin
        imm         = imm_i;
        alu_op      = arith_op;
        alu_src_imm = 1'b1;
        reg_wr      = 1'b1;
      end
      OP_LUI: begin
        // value taken from imm in execute
        imm    = imm_u;
        reg_wr = 1'b1;
        is_lui = 1'b1;
      end
      OP_LOAD: begin
        // address is rs1 + imm through the adder
        imm         = imm_i;
        alu_src_imm = 1'b1;
        reg_wr      = 1'b1;
        mem_rd      = 1'b1;
      end
      OP_STORE: begin
        imm         = imm_s;
        alu_src_imm = 1'b1;
        mem_wr      = 1'b1;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
      end
      OP_JAL: begin
        imm    = imm_j;
        reg_wr = 1'b1;
        is_jal = 1'b1;
      end
      OP_JALR: begin
        imm     = imm_i;
        reg_wr  = 1'b1;
        is_jalr = 1'b1;
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// ==== source/rv_regfile.sv ====
`include "rv_core_params.svh"

module rv_regfile import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rd_data1,
  output word_t    rd_data2,
  input  logic     w_en,
  input  reg_idx_t w_idx,
  input  word_t    w_data
);

  // x1..x31, x0 has no storage
  word_t regs [1:`RV_NREGS-1];

  // write on the edge, x0 writes dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && w_idx != '0) begin
      regs[w_idx] <= w_data;
    end
  end

  // combinational reads
  // same-cycle write shows through so a reader three slots back sees it
  assign rd_data1 = (rs1 == '0) ? '0 :
                    (w_en && w_idx == rs1) ? w_data : regs[rs1];

  assign rd_data2 = (rs2 == '0) ? '0 :
                    (w_en && w_idx == rs2) ? w_data : regs[rs2];

endmodule

// ==== source/rv_alu.sv ====
module rv_alu import rv_core_pkg::*; (
  input  alu_op_t alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  // shift amount, low five bits only
  logic [4:0] shamt;
  // signed compare
  logic       lt;

  assign shamt = b[4:0];
  assign lt    = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      ALU_SLT: begin
        // 0 or 1
        result = {31'b0, lt};
      end
      ALU_SLL: begin
        result = a << shamt;
      end
      ALU_SRL: begin
        // logical, zero fill
        result = a >> shamt;
      end
      default: begin
        result = a + b;
      end
    endcase
  end

endmodule

// ==== source/rv_branch_unit.sv ====
module rv_branch_unit import rv_core_pkg::*; (
  input  word_t   pc,
  input  word_t   data1,
  input  word_t   data2,
  input  word_t   imm,
  input  funct3_t funct3,
  input  logic    is_branch,
  input  logic    is_jal,
  input  logic    is_jalr,
  output logic    take,
  output word_t   target
);

  // branch condition met
  logic  cond;
  // jalr sum before bit 0 is cleared
  word_t jalr_sum;

  // beq, bne, blt
  always_comb begin
    case (funct3)
      3'b000:  cond = (data1 == data2);
      3'b001:  cond = (data1 != data2);
      3'b100:  cond = ($signed(data1) < $signed(data2));
      // other conditions never taken
      default: cond = 1'b0;
    endcase
  end

  // jumps always go
  assign take = is_jal | is_jalr | (is_branch & cond);

  assign jalr_sum = data1 + imm;

  // pc relative for branch and jal
  assign target = is_jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;

endmodule

// ==== source/rv_core.sv ====
`include "rv_core_params.svh"

module rv_core import rv_core_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  output word_t addr,
  input  word_t instr,
  output word_t mem_addr,
  output word_t mem_wdata,
  output logic  mem_wr_en,
  input  word_t mem_rdata
);

  // decode stage
  logic     d_valid;
  word_t    d_instr;
  word_t    d_pc;
  reg_idx_t rs1, rs2, rd;
  word_t    imm, rd_data1, rd_data2;
  funct3_t  funct3;
  alu_op_t  alu_op;
  logic     alu_src_imm, reg_wr, mem_rd, mem_wr;
  logic     is_branch, is_jal, is_jalr, is_lui;
  // execute stage
  logic     x_valid;
  word_t    x_pc, x_rdata1, x_rdata2, x_imm;
  funct3_t  x_funct3;
  alu_op_t  x_alu_op;
  reg_idx_t x_rd;
  logic     x_alu_src_imm, x_reg_wr, x_mem_rd, x_mem_wr;
  logic     x_is_branch, x_is_jal, x_is_jalr, x_is_lui;
  word_t    alu_b, alu_result, target, x_result;
  logic     take, redirect;
  // memory and write back stages
  logic     m_valid, m_reg_wr, m_mem_rd, m_mem_wr;
  word_t    m_result, m_wdata;
  reg_idx_t m_rd;
  logic     w_valid, w_reg_wr, w_mem_rd, w_en;
  word_t    w_result, w_rdata, w_data;
  reg_idx_t w_rd;

  ////////////////////////////////////////////////////////////////////////////
  // fetch and decode
  ////////////////////////////////////////////////////////////////////////////

  rv_fetch u_fetch (
    .clk(clk), .arst_n(arst_n), .redirect(redirect), .redirect_pc(target), .addr(addr)
  );

  // fetch slot killed by a taken branch in execute
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_valid <= 1'b0;
      d_instr <= `RV_NOP;
    end else begin
      d_valid <= ~redirect;
      d_instr <= redirect ? `RV_NOP : instr;
    end
  end

  always_ff @(posedge clk) begin
    d_pc <= addr;
  end

  rv_decode_ctrl u_decode (
    .instr(d_instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .funct3(funct3),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .reg_wr(reg_wr), .mem_rd(mem_rd),
    .mem_wr(mem_wr), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_lui(is_lui)
  );

  rv_regfile u_regfile (
    .clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .rd_data1(rd_data1),
    .rd_data2(rd_data2), .w_en(w_en), .w_idx(w_rd), .w_data(w_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////////////////////

  // decode slot also killed on redirect
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= d_valid & ~redirect;
    end
  end

  always_ff @(posedge clk) begin
    x_pc          <= d_pc;
    x_rdata1      <= rd_data1;
    x_rdata2      <= rd_data2;
    x_imm         <= imm;
    x_funct3      <= funct3;
    x_alu_op      <= alu_op;
    x_rd          <= rd;
    x_alu_src_imm <= alu_src_imm;
    x_reg_wr      <= reg_wr;
    x_mem_rd      <= mem_rd;
    x_mem_wr      <= mem_wr;
    x_is_branch   <= is_branch;
    x_is_jal      <= is_jal;
    x_is_jalr     <= is_jalr;
    x_is_lui      <= is_lui;
  end

  assign alu_b = x_alu_src_imm ? x_imm : x_rdata2;

  rv_alu u_alu (.alu_op(x_alu_op), .a(x_rdata1), .b(alu_b), .result(alu_result));

  rv_branch_unit u_branch (
    .pc(x_pc), .data1(x_rdata1), .data2(x_rdata2), .imm(x_imm), .funct3(x_funct3),
    .is_branch(x_is_branch), .is_jal(x_is_jal), .is_jalr(x_is_jalr),
    .take(take), .target(target)
  );

  // only a live instruction may steer fetch
  assign redirect = x_valid & take;

  // lui value, link value, else alu
  assign x_result = x_is_lui ? x_imm :
                    (x_is_jal | x_is_jalr) ? x_pc + 32'd4 : alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // memory and write back
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
      w_valid <= 1'b0;
    end else begin
      m_valid <= x_valid;
      w_valid <= m_valid;
    end
  end

  always_ff @(posedge clk) begin
    m_result <= x_result;
    m_wdata  <= x_rdata2;
    m_rd     <= x_rd;
    m_reg_wr <= x_reg_wr;
    m_mem_rd <= x_mem_rd;
    m_mem_wr <= x_mem_wr;
    // load data captured here
    w_result <= m_result;
    w_rdata  <= mem_rdata;
    w_rd     <= m_rd;
    w_reg_wr <= m_reg_wr;
    w_mem_rd <= m_mem_rd;
  end

  // word address from the adder
  assign mem_addr  = m_result;
  assign mem_wdata = m_wdata;
  assign mem_wr_en = m_valid & m_mem_wr;

  // write back source
  assign w_data = w_mem_rd ? w_rdata : w_result;
  assign w_en   = w_valid & w_reg_wr;

endmodule

// ==== sim/rv_core_props.sv ====
`include "rv_core_params.svh"

module rv_core_props import rv_core_pkg::*; (
  input logic  clk,
  input logic  arst_n,
  input word_t addr,
  input logic  redirect,
  input logic  mem_wr_en
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////////////////////
  // fetch and store strobe rules
  ////////////////////////////////////////////////////////////////////////////

  // first cycle out of reset fetches the reset vector
  reset_pc_a: assert property (@(posedge clk) $rose(arst_n) |-> addr == `RV_RESET_PC)
    else $error("fetch did not start at the reset pc");

  // sequential step unless execute redirected
  pc_step_a: assert property (@(posedge clk) disable iff (!arst_n)
    $past(arst_n) && !$past(redirect) |-> addr == $past(addr) + 32'd4)
    else $error("fetch address did not advance by four");

  // no store while held in reset
  no_store_in_reset_a: assert property (@(posedge clk) !arst_n |-> !mem_wr_en)
    else $error("store strobe high during reset");

endmodule

bind rv_core rv_core_props u_props (
  .clk(clk), .arst_n(arst_n), .addr(addr), .redirect(redirect), .mem_wr_en(mem_wr_en)
);

// ==== sim/rv_core_tb.sv ====
`include "rv_core_params.svh"

module rv_core_tb import rv_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // body blocks, each one instruction plus two slots
  localparam int NBLK      = 48;
  localparam int DUMP_BASE = 'h300;
  localparam int TIMEOUT   = 4000;

  logic  clk = 1'b0;
  logic  arst_n;
  word_t addr;
  word_t instr;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_wr_en;
  word_t mem_rdata;

  // program image, dut data memory, model memory and model registers
  word_t imem [0:1023];
  word_t dmem [0:255];
  word_t mmem [0:255];
  word_t mregs [0:31];
  int    prog_len = 0;
  word_t loop_pc;
  word_t seed = 32'hb046ac90;
  word_t exp_addr [$];
  word_t exp_data [$];
  int    exp_total = 0;
  int    store_count = 0;
  int    errors = 0;

  always #50 clk = ~clk;

  rv_core u_dut (
    .clk(clk), .arst_n(arst_n), .addr(addr), .instr(instr), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wr_en(mem_wr_en), .mem_rdata(mem_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // memories
  ////////////////////////////////////////////////////////////////////////////

  // past the end of the program only nops come back
  assign instr     = (addr[31:2] < prog_len) ? imem[addr[11:2]] : `RV_NOP;
  assign mem_rdata = dmem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (mem_wr_en) begin
      dmem[mem_addr[9:2]] <= mem_wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // encoders and program generator
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t next_rand();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  function automatic word_t rtype_word(input logic [6:0] f7, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input funct3_t f3,
                                       input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t itype_word(input logic [11:0] imm, input reg_idx_t rs1,
                                       input funct3_t f3, input reg_idx_t rd,
                                       input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // sw only
  function automatic word_t stype_word(input logic [11:0] imm, input reg_idx_t rs2,
                                       input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t btype_word(input logic [12:0] imm, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t jtype_word(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    word_t    r;
    word_t    r2;
    word_t    w;
    int       tgt;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    funct3_t  f3;
    logic     ctl;
    for (int b = 0; b < NBLK; b++) begin
      r   = next_rand();
      r2  = next_rand();
      rd  = r[8:4];
      rs1 = r[13:9];
      rs2 = r[18:14];
      f3  = r[21:19];
      // forward only, dump start at the latest
      tgt = b + 1 + int'(r[23:22]) % 3;
      if (tgt > NBLK) tgt = NBLK;
      ctl = 1'b0;
      case (r[31:24] % 11)
        0, 1, 2: begin
          // sltu slot reused for sub
          if (f3 == 3'd3) w = rtype_word(7'h20, rs2, rs1, 3'd0, rd);
          else w = rtype_word(7'h00, rs2, rs1, f3, rd);
        end
        3, 4: begin
          // addi, slti, xori, ori, andi
          if (f3 inside {3'd1, 3'd3, 3'd5}) f3 = 3'd0;
          w = itype_word(r2[11:0], rs1, f3, rd, OP_IMM);
        end
        5: w = {r2[31:12], rd, OP_LUI};
        6: w = itype_word({2'b00, r2[7:0], 2'b00}, 5'd0, 3'd2, rd, OP_LOAD);
        7: w = stype_word({2'b00, r2[7:0], 2'b00}, rs2, 5'd0);
        8: begin
          // equal operands now and then so beq gets taken
          if (r2[0]) rs2 = rs1;
          f3  = (r2[2:1] == 2'd0) ? 3'd0 : (r2[2:1] == 2'd1) ? 3'd1 : 3'd4;
          w   = btype_word(13'((tgt - b) * 12), rs2, rs1, f3);
          ctl = 1'b1;
        end
        9: begin
          w   = jtype_word(21'((tgt - b) * 12), rd);
          ctl = 1'b1;
        end
        default: begin
          // absolute target off x0, bit 0 sometimes set
          w   = itype_word(12'(tgt * 12) | {11'b0, r2[0]}, 5'd0, 3'd0, rd, OP_JALR);
          ctl = 1'b1;
        end
      endcase
      emit(w);
      // bait stores behind control flow, nops otherwise
      emit(ctl ? stype_word({5'b00111, r2[24:20], 2'b00}, r[30:26], 5'd0) : `RV_NOP);
      emit(ctl ? stype_word({5'b00111, r2[29:25], 2'b00}, r[29:25], 5'd0) : `RV_NOP);
    end
    // dump x1..x31, then spin
    for (int i = 1; i < `RV_NREGS; i++) begin
      emit(stype_word(12'(DUMP_BASE + 4 * i), reg_idx_t'(i), 5'd0));
    end
    loop_pc = word_t'(prog_len * 4);
    emit(jtype_word(21'd0, 5'd0));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // ISA reference, one instruction per call
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t ref_step(input word_t pc);
    word_t ins;
    word_t a;
    word_t b;
    word_t res;
    word_t ea;
    word_t nxt;
    logic  wr;
    logic  cond;
    ins = imem[pc[11:2]];
    a   = mregs[ins[19:15]];
    b   = mregs[ins[24:20]];
    nxt = pc + 32'd4;
    res = '0;
    wr  = 1'b0;
    case (ins[6:0])
      7'b0110011, 7'b0010011: begin
        // immediate forms use the I immediate as b
        if (ins[5] == 1'b0) b = {{20{ins[31]}}, ins[31:20]};
        wr = 1'b1;
        case (ins[14:12])
          3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd4: res = a ^ b;
          3'd5: res = a >> b[4:0];
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0110111: begin
        wr  = 1'b1;
        res = {ins[31:12], 12'd0};
      end
      7'b0000011: begin
        ea  = a + {{20{ins[31]}}, ins[31:20]};
        wr  = 1'b1;
        res = mmem[ea[9:2]];
      end
      7'b0100011: begin
        ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mmem[ea[9:2]] = b;
        exp_addr.push_back(ea);
        exp_data.push_back(b);
      end
      7'b1100011: begin
        case (ins[14:12])
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          default: cond = ($signed(a) < $signed(b));
        endcase
        if (cond) nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      7'b1101111: begin
        wr  = 1'b1;
        res = pc + 32'd4;
        nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin
        wr  = 1'b1;
        res = pc + 32'd4;
        ea  = a + {{20{ins[31]}}, ins[31:20]};
        nxt = {ea[31:1], 1'b0};
      end
      default: ;
    endcase
    // x0 stays zero
    if (wr && ins[11:7] != 5'd0) mregs[ins[11:7]] = res;
    return nxt;
  endfunction

  task automatic check_val(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // store checker, in order against the reference queue
  always @(negedge clk) begin
    if (!arst_n && mem_wr_en) begin
      $display("store strobe raised while reset was asserted");
      errors++;
    end else if (mem_wr_en) begin
      store_count++;
      if (exp_addr.size() == 0) begin
        $display("store seen after the reference ran out of stores");
        errors++;
      end else begin
        check_val("store_addr", exp_addr.pop_front(), mem_addr);
        check_val("store_data", exp_data.pop_front(), mem_wdata);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    word_t pc;
    int    steps;
    int    guard;
    arst_n = 1'b0;
    build_program();
    // same preload for dut and model memory
    for (int i = 0; i < 256; i++) begin
      dmem[i] = (word_t'(i) * 32'h9e37_79b9) ^ 32'h0bad_f00d;
      mmem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    // run the reference over the whole path first
    pc    = `RV_RESET_PC;
    steps = 0;
    while (pc != loop_pc && steps < TIMEOUT) begin
      pc = ref_step(pc);
      steps++;
    end
    if (pc != loop_pc) begin
      $display("reference model never reached the final self loop");
      errors++;
    end
    exp_total = exp_addr.size();
    // three cycles of reset
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    check_val("reset_pc", `RV_RESET_PC, addr);
    guard = 0;
    while (addr !== loop_pc && guard < TIMEOUT) begin
      @(negedge clk);
      guard++;
    end
    if (addr !== loop_pc) begin
      $display("timeout: core never fetched the final self loop");
      errors++;
    end
    // let the last dump stores leave the pipeline
    repeat (4) @(negedge clk);
    check_val("store_count", word_t'(exp_total), word_t'(store_count));
    $display("errors: %0d, stores: %0d of %0d expected", errors, store_count, exp_total);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+source
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode_ctrl.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_branch_unit.sv
source/rv_core.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv

// ==== Makefile ====
# verilator build and run for rv_core
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  := Test failures found
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
